// ==== dv/ecc_ref.svh ====
`ifndef ECC_REF_SVH
`define ECC_REF_SVH

////////////////////////////////////////////////////////////
// reference model for one ecc block
////////////////////////////////////////////////////////////

localparam int BLOCK_LEN = 128;

typedef ecc_pkg::byte_t block_t [BLOCK_LEN];

// 32-bit fibonacci lfsr, taps 32 22 2 1
// the new bit enters at bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	logic fb;

	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// every set bit toggles one even/odd slot per bit of its position
function automatic ecc_pkg::cp_t expected_cp(input block_t blk);
	ecc_pkg::cp_t code;
	logic [2:0]   pos;

	code = 8'hC0;
	for (int i = 0; i < BLOCK_LEN; i++)
	begin
		for (int b = 0; b < 8; b++)
		begin
			if (blk[i][b])
			begin
				pos = 3'(b);
				for (int k = 0; k < 3; k++)
				begin
					code[2*k + int'(pos[k])] ^= 1'b1;
				end
			end
		end
	end
	return code;
endfunction

// byte parity lands in one slot per bit of the byte index
function automatic ecc_pkg::rp_t expected_rp(input block_t blk);
	ecc_pkg::rp_t code;
	logic [6:0]   idx;
	logic         p;

	code = 16'hC000;
	for (int i = 0; i < BLOCK_LEN; i++)
	begin
		p   = ^blk[i];
		idx = 7'(i);
		for (int k = 0; k < 7; k++)
		begin
			code[2*k + int'(idx[k])] ^= p;
		end
	end
	return code;
endfunction

`endif

// ==== dv/nand_ecc_gen_tb.sv ====
`timescale 1ns/1ns

module nand_ecc_gen_tb;

	`include "ecc_ref.svh"

	typedef enum int
	{
		KIND_ZERO,
		KIND_SINGLE,
		KIND_RANDOM,
		KIND_ABORT
	} kind_t;

	// one expected code and the cycle its pulse is due
	typedef struct packed
	{
		int           due;
		int           row;
		ecc_pkg::cp_t cp;
		ecc_pkg::rp_t rp;
	} result_t;

	localparam int NUM_ROWS     = 11;
	localparam int RESET_CYCLES = 10;
	localparam int ABORT_BYTES  = 45;
	localparam int ABORT_HOLD   = 4;

	logic           clk = 1'b0;
	logic           rst;
	ecc_pkg::byte_t data;
	logic           data_valid;
	ecc_pkg::cp_t   cp;
	ecc_pkg::rp_t   rp;
	logic           ecc_valid;

	// stimulus table
	string row_name [NUM_ROWS];
	kind_t row_kind [NUM_ROWS];
	int    row_r    [NUM_ROWS];
	int    row_c    [NUM_ROWS];
	int    row_gap  [NUM_ROWS];
	int    row_post [NUM_ROWS];
	int    rows_loaded;

	block_t      blk;
	logic [31:0] lfsr_state;
	result_t     exp_q [$];
	int          blocks_sent;

	int   cycle = 0;
	int   cycle_limit;
	logic checks_on = 1'b0;

	// monitor state
	ecc_pkg::cp_t held_cp;
	ecc_pkg::rp_t held_rp;
	string        held_name;
	logic         due_now;
	result_t      got;
	int           results_seen = 0;

	nand_ecc_gen dut_i
	(
		.clk        (clk),
		.rst        (rst),
		.data       (data),
		.data_valid (data_valid),
		.cp         (cp),
		.rp         (rp),
		.ecc_valid  (ecc_valid)
	);

	initial
	begin
		forever
		begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle > cycle_limit)
		begin
			$display("simulation timed out after %0d cycles", cycle);
			$display("TEST FAILED");
			$fatal(1, "no progress within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_cp(input string name, input ecc_pkg::cp_t exp_val,
		input ecc_pkg::cp_t act_val);
		if (act_val !== exp_val)
		begin
			$display("Error: %s cp expected %h actual %h", name, exp_val, act_val);
			$display("TEST FAILED");
			$fatal(1, "cp mismatch");
		end
	endtask

	task automatic check_rp(input string name, input ecc_pkg::rp_t exp_val,
		input ecc_pkg::rp_t act_val);
		if (act_val !== exp_val)
		begin
			$display("Error: %s rp expected %h actual %h", name, exp_val, act_val);
			$display("TEST FAILED");
			$fatal(1, "rp mismatch");
		end
	endtask

	task automatic check_valid(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val)
		begin
			$display("Error: %s ecc_valid expected %b actual %b", name, exp_val, act_val);
			$display("TEST FAILED");
			$fatal(1, "ecc_valid mismatch");
		end
	endtask

	// outputs settle on the rising edge, so look at them on the falling one
	always @(negedge clk)
	begin
		if (!checks_on)
		begin
			held_cp   = '0;
			held_rp   = '0;
			held_name = "reset";
		end
		else
		begin
			due_now = (exp_q.size() > 0) && (exp_q[0].due == cycle);
			check_valid(due_now ? row_name[exp_q[0].row] : held_name, due_now, ecc_valid);
			if (due_now)
			begin
				got = exp_q.pop_front();
				check_cp(row_name[got.row], got.cp, cp);
				check_rp(row_name[got.row], got.rp, rp);
				held_cp   = got.cp;
				held_rp   = got.rp;
				held_name = row_name[got.row];
				results_seen++;
			end
			else
			begin
				// codes must hold between pulses
				check_cp(held_name, held_cp, cp);
				check_rp(held_name, held_rp, rp);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic add_row(input string name, input kind_t kind, input int r, input int c,
		input int gap, input int post);
		row_name[rows_loaded] = name;
		row_kind[rows_loaded] = kind;
		row_r[rows_loaded]    = r;
		row_c[rows_loaded]    = c;
		row_gap[rows_loaded]  = gap;
		row_post[rows_loaded] = post;
		rows_loaded++;
	endtask

	task automatic load_table();
		//      name                kind         row  col gap post
		add_row("zero_block",       KIND_ZERO,   0,   0,  0,  6);
		add_row("single_r0_c0",     KIND_SINGLE, 0,   0,  0,  3);
		add_row("single_r127_c7",   KIND_SINGLE, 127, 7,  0,  3);
		add_row("single_r85_c2",    KIND_SINGLE, 85,  2,  1,  3);
		add_row("single_r42_c5",    KIND_SINGLE, 42,  5,  0,  6);
		add_row("random_gap1",      KIND_RANDOM, 0,   0,  1,  5);
		add_row("random_gap3_hold", KIND_RANDOM, 0,   0,  3,  12);
		add_row("back_to_back_a",   KIND_RANDOM, 0,   0,  0,  0);
		add_row("back_to_back_b",   KIND_RANDOM, 0,   0,  0,  6);
		add_row("reset_abort",      KIND_ABORT,  0,   0,  0,  20);
		add_row("random_after",     KIND_RANDOM, 0,   0,  2,  8);
	endtask

	// one lfsr step per bit taken
	task automatic random_byte(output ecc_pkg::byte_t b);
		b = '0;
		for (int n = 0; n < 8; n++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	task automatic drive_byte(input ecc_pkg::byte_t b);
		@(negedge clk);
		data       = b;
		data_valid = 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			data_valid = 1'b0;
			data       = 8'hFF;
		end
	endtask

	task automatic apply_reset(input int n);
		@(negedge clk);
		checks_on  <= 1'b0;
		data_valid = 1'b0;
		// monitor is already off when rst rises
		@(negedge clk);
		rst = 1'b1;
		repeat (n) @(negedge clk);
		rst       = 1'b0;
		checks_on <= 1'b1;
	endtask

	task automatic build_block(input int i);
		for (int n = 0; n < BLOCK_LEN; n++)
		begin
			if (row_kind[i] == KIND_RANDOM || row_kind[i] == KIND_ABORT)
				random_byte(blk[n]);
			else
				blk[n] = '0;
		end
		if (row_kind[i] == KIND_SINGLE)
			blk[row_r[i]][row_c[i]] = 1'b1;
	endtask

	task automatic send_block(input int i);
		result_t item;

		for (int n = 0; n < BLOCK_LEN; n++)
		begin
			drive_byte(blk[n]);
			if (n == BLOCK_LEN - 1)
			begin
				// taken on the next rising edge and pulsed on the one after
				item.due = cycle + 2;
				item.row = i;
				item.cp  = expected_cp(blk);
				item.rp  = expected_rp(blk);
				exp_q.push_back(item);
			end
			else
			begin
				idle_cycles(row_gap[i]);
			end
		end
		idle_cycles(row_post[i]);
	endtask

	task automatic run_row(input int i);
		ecc_pkg::byte_t junk;

		if (row_kind[i] == KIND_ABORT)
		begin
			// partial block that the reset throws away
			for (int n = 0; n < ABORT_BYTES; n++)
			begin
				random_byte(junk);
				drive_byte(junk);
				idle_cycles(row_gap[i]);
			end
			apply_reset(ABORT_HOLD);
		end
		build_block(i);
		send_block(i);
		blocks_sent++;
	endtask

	initial
	begin
		rst         = 1'b1;
		data        = '0;
		data_valid  = 1'b0;
		lfsr_state  = 32'h8f23_1ba3;
		rows_loaded = 0;
		blocks_sent = 0;
		load_table();

		cycle_limit = RESET_CYCLES + 16;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			cycle_limit += BLOCK_LEN * (1 + row_gap[i]) + row_post[i] + 8;
			if (row_kind[i] == KIND_ABORT)
				cycle_limit += ABORT_BYTES * (1 + row_gap[i]) + ABORT_HOLD + 2;
		end

		repeat (RESET_CYCLES) @(negedge clk);
		rst       = 1'b0;
		checks_on <= 1'b1;

		for (int i = 0; i < NUM_ROWS; i++)
		begin
			run_row(i);
		end

		// wait for the last code in flight
		while (results_seen < blocks_sent)
			idle_cycles(1);
		idle_cycles(4);

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== logic/ecc_code_former.sv ====
`timescale 1ns/1ns

module ecc_code_former
(
	input  logic               clk,
	input  logic               rst,
	input  ecc_pkg::col_sum_t  col_sum,
	input  ecc_pkg::line_par_t line_par,
	input  logic               block_done,
	output ecc_pkg::cp_t       cp,
	output ecc_pkg::rp_t       rp,
	output logic               ecc_valid
);

	// column parities before padding
	logic [2*ecc_pkg::COL_BITS-1:0] col_par;

	ecc_pkg::cp_t cp_next;
	ecc_pkg::rp_t rp_next;

	////////////////////////////////////////////////////////////
	// column address parities
	////////////////////////////////////////////////////////////

	// same even/odd split as the line parities, but over bit positions
	function automatic logic [2*ecc_pkg::COL_BITS-1:0] fold_columns
	(
		input ecc_pkg::col_sum_t cs
	);
		logic [2*ecc_pkg::COL_BITS-1:0] par;

		par = '0;
		for (int j = 0; j < $bits(cs); j++)
		begin
			for (int k = 0; k < ecc_pkg::COL_BITS; k++)
			begin
				par[2*k + j[k]] = par[2*k + j[k]] ^ cs[j];
			end
		end
		return par;
	endfunction

	assign col_par = fold_columns(col_sum);

	// unused top bits are ones
	assign cp_next = {2'b11, col_par};
	assign rp_next = {2'b11, line_par};

	////////////////////////////////////////////////////////////
	// result registers
	////////////////////////////////////////////////////////////

	// codes hold until the next block completes
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cp <= '0;
			rp <= '0;
		end
		else if (block_done)
		begin
			cp <= cp_next;
			rp <= rp_next;
		end
	end

	// one pulse per block, aligned with the new codes
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			ecc_valid <= 1'b0;
		else
			ecc_valid <= block_done;
	end

endmodule

// ==== logic/ecc_pkg.sv ====
package ecc_pkg;

	////////////////////////////////////////////////////////////
	// block geometry
	////////////////////////////////////////////////////////////

	// bytes covered by one cp/rp pair
	localparam int BLOCK_BYTES = 128;

	// byte index width within a block
	localparam int IDX_BITS = $clog2(BLOCK_BYTES);

	// bit address width within one byte
	localparam int COL_BITS = 3;

	////////////////////////////////////////////////////////////
	// data path types
	////////////////////////////////////////////////////////////

	// one byte of the page stream
	typedef logic [2**COL_BITS-1:0] byte_t;

	// position of a byte in its block
	typedef logic [IDX_BITS-1:0] byte_idx_t;

	// xor of all bytes accepted so far
	typedef logic [2**COL_BITS-1:0] col_sum_t;

	// two bits per index bit
	// bit 2k collects bytes with index bit k clear
	// bit 2k+1 collects bytes with index bit k set
	typedef logic [2*IDX_BITS-1:0] line_par_t;

	////////////////////////////////////////////////////////////
	// output codes
	////////////////////////////////////////////////////////////

	// six column parities over the bit positions of col_sum
	// top two bits always one
	typedef logic [2*COL_BITS+1:0] cp_t;

	// fourteen line parities straight from line_par_t
	// top two bits always one
	typedef logic [2*IDX_BITS+1:0] rp_t;

endpackage

// ==== logic/nand_ecc_gen.sv ====
`timescale 1ns/1ns

module nand_ecc_gen
(
	input  logic           clk,
	input  logic           rst,
	input  ecc_pkg::byte_t data,
	input  logic           data_valid,
	output ecc_pkg::cp_t   cp,
	output ecc_pkg::rp_t   rp,
	output logic           ecc_valid
);

	// final sums of a block, valid while block_done is high
	ecc_pkg::col_sum_t  col_sum;
	ecc_pkg::line_par_t line_par;
	logic               block_done;

	////////////////////////////////////////////////////////////
	// accumulation
	////////////////////////////////////////////////////////////

	// one edge after byte 127 the sums are complete
	parity_accumulator parity_accumulator_i
	(
		.clk        (clk),
		.rst        (rst),
		.data       (data),
		.data_valid (data_valid),
		.col_sum    (col_sum),
		.line_par   (line_par),
		.block_done (block_done)
	);

	////////////////////////////////////////////////////////////
	// code forming
	////////////////////////////////////////////////////////////

	// second edge after byte 127 registers cp/rp and ecc_valid,
	// while the next block is already accumulating
	ecc_code_former ecc_code_former_i
	(
		.clk        (clk),
		.rst        (rst),
		.col_sum    (col_sum),
		.line_par   (line_par),
		.block_done (block_done),
		.cp         (cp),
		.rp         (rp),
		.ecc_valid  (ecc_valid)
	);

endmodule

// ==== logic/parity_accumulator.sv ====
`timescale 1ns/1ns

module parity_accumulator
(
	input  logic               clk,
	input  logic               rst,
	input  ecc_pkg::byte_t     data,
	input  logic               data_valid,
	output ecc_pkg::col_sum_t  col_sum,
	output ecc_pkg::line_par_t line_par,
	output logic               block_done
);

	// position of the next byte to be accepted
	ecc_pkg::byte_idx_t byte_idx;
	logic               last_byte;

	// parity of the incoming byte
	logic byte_par;

	// what the current byte adds to each sum
	ecc_pkg::col_sum_t  col_add;
	ecc_pkg::line_par_t line_add;

	// starting point, zero right after a block ends
	ecc_pkg::col_sum_t  col_base;
	ecc_pkg::line_par_t line_base;

	ecc_pkg::col_sum_t  col_next;
	ecc_pkg::line_par_t line_next;

	////////////////////////////////////////////////////////////
	// byte counter
	////////////////////////////////////////////////////////////

	// index is exactly log2 of the block size so it wraps by itself
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			byte_idx <= '0;
		else if (data_valid)
			byte_idx <= byte_idx + 1'b1;
	end

	assign last_byte = (byte_idx == ecc_pkg::byte_idx_t'(ecc_pkg::BLOCK_BYTES - 1));

	// high for the one cycle after byte 127 was taken
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			block_done <= 1'b0;
		else
			block_done <= data_valid && last_byte;
	end

	////////////////////////////////////////////////////////////
	// contribution of the current byte
	////////////////////////////////////////////////////////////

	assign byte_par = ^data;

	always_comb
	begin
		col_add  = data_valid ? data : '0;
		line_add = '0;
		// pick even or odd slot by each bit of the index
		for (int k = 0; k < ecc_pkg::IDX_BITS; k++)
		begin
			line_add[2*k + byte_idx[k]] = data_valid & byte_par;
		end
	end

	////////////////////////////////////////////////////////////
	// running sums
	////////////////////////////////////////////////////////////

	// finished block is still visible while block_done is high,
	// so the new block starts from zero on that edge
	assign col_base  = block_done ? '0 : col_sum;
	assign line_base = block_done ? '0 : line_par;

	assign col_next  = col_base ^ col_add;
	assign line_next = line_base ^ line_add;

	// reset drops any partial block
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col_sum  <= '0;
			line_par <= '0;
		end
		else if (data_valid || block_done)
		begin
			col_sum  <= col_next;
			line_par <= line_next;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the nand ecc testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f vlog.f --top-module nand_ecc_gen_tb \
	-o nand_ecc_gen_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/nand_ecc_gen_tb > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if ! grep -q "TEST PASSED" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

// ==== vlog.f ====
+incdir+dv
logic/ecc_pkg.sv
logic/parity_accumulator.sv
logic/ecc_code_former.sv
logic/nand_ecc_gen.sv
dv/nand_ecc_gen_tb.sv
